/* compile.f */
+incdir+.
machine_mode_pkg.sv
prv_internal_if.sv
csr_rfile.sv
prv_control.sv
priv_unit.sv
tb_priv_unit.sv

/* csr_rfile.sv */
// Machine CSR register file with counters and timer; serves single-cycle swap/set/clear access
`timescale 1ns/1ps

module csr_rfile #(
  parameter machine_mode_pkg::word_t TRAP_VECTOR = 32'h0000_01C0,
  parameter machine_mode_pkg::word_t HART_ID     = 32'h0000_0000
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  machine_mode_pkg::csr_addr_t  csr_addr,
  input  logic                         csr_swap,
  input  logic                         csr_set,
  input  logic                         csr_clr,
  input  machine_mode_pkg::word_t      csr_wdata,
  output machine_mode_pkg::word_t      csr_rdata,
  input  logic                         instr_retired,
  prv_internal_if.csr                  prv_if
);
  import machine_mode_pkg::*;

  // Stored state, constant fields are filled in below
  logic        ie_q;
  logic        ie1_q;
  logic        msie_q;
  logic        mtie_q;
  logic        msip_q;
  logic        mtip_q;
  word_t       mscratch_q;
  word_t       mepc_q;
  word_t       mbadaddr_q;
  word_t       mtimecmp_q;
  mcause_u     mcause_q;
  logic [63:0] mtime_q;
  logic [63:0] cycle_q;
  logic [63:0] instret_q;

  word_t    mcpuid;
  mstatus_t mstatus;
  mie_t     mie;
  mip_t     mip;

  logic     csr_op;
  logic     valid_addr;
  word_t    rup_data;
  mstatus_t rup_mstatus;
  mie_t     rup_mie;
  logic     wr_mstatus;
  logic     wr_mie;
  logic     wr_mscratch;
  logic     wr_mepc;
  logic     wr_mtimecmp;
  logic     wr_mtime;
  logic     wr_mtimeh;
  logic     timer_match;

  assign mcpuid = {BASE_RV32, 4'b0000, MCPUID_EXT_I};

  always_comb begin
    mstatus      = '0;        // MBARE, no FPU, no extension state
    mstatus.prv  = M_MODE;
    mstatus.prv1 = M_MODE;
    mstatus.prv2 = M_MODE;
    mstatus.prv3 = M_MODE;
    mstatus.ie1  = ie1_q;
    mstatus.ie   = ie_q;
  end

  always_comb begin
    mie      = '0;
    mie.msie = msie_q;
    mie.mtie = mtie_q;
    mip      = '0;
    mip.msip = msip_q;
    mip.mtip = mtip_q;
  end

  // Read-modify-write value for the addressed CSR
  assign csr_op   = csr_swap | csr_set | csr_clr;
  assign rup_data = csr_swap ? csr_wdata :
                    csr_clr  ? (csr_rdata & ~csr_wdata) :
                    csr_set  ? (csr_rdata | csr_wdata) :
                    csr_rdata;
  assign rup_mstatus = mstatus_t'(rup_data);
  assign rup_mie     = mie_t'(rup_data);

  // Only these are writable from the pipeline
  assign wr_mstatus  = csr_op & (csr_addr == MSTATUS_ADDR);
  assign wr_mie      = csr_op & (csr_addr == MIE_ADDR);
  assign wr_mscratch = csr_op & (csr_addr == MSCRATCH_ADDR);
  assign wr_mepc     = csr_op & (csr_addr == MEPC_ADDR);
  assign wr_mtimecmp = csr_op & (csr_addr == MTIMECMP_ADDR);
  assign wr_mtime    = csr_op & (csr_addr == MTIME_ADDR);
  assign wr_mtimeh   = csr_op & (csr_addr == MTIMEH_ADDR);

  assign timer_match = (mtime_q[31:0] == mtimecmp_q);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ie_q       <= 1'b1;
      ie1_q      <= 1'b0;
      msie_q     <= 1'b0;
      mtie_q     <= 1'b0;
      msip_q     <= 1'b0;
      mtip_q     <= 1'b0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mbadaddr_q <= '0;
      mtimecmp_q <= '0;
      mcause_q   <= '0;
      mtime_q    <= '0;
      cycle_q    <= '0;
      instret_q  <= '0;
    end else begin
      // Pipeline write beats the trap controller
      if (wr_mstatus) begin
        ie_q  <= rup_mstatus.ie;
        ie1_q <= rup_mstatus.ie1;
      end else if (prv_if.mstatus_rup) begin
        ie_q  <= prv_if.mstatus_next.ie;
        ie1_q <= prv_if.mstatus_next.ie1;
      end

      if (wr_mie) begin
        msie_q <= rup_mie.msie;
        mtie_q <= rup_mie.mtie;
      end

      msip_q <= prv_if.soft_int;
      if (wr_mtimecmp)
        mtip_q <= 1'b0;         // Held until software rearms the compare
      else if (timer_match)
        mtip_q <= 1'b1;

      if (wr_mscratch)
        mscratch_q <= rup_data;
      if (wr_mepc)
        mepc_q <= rup_data;
      else if (prv_if.mepc_rup)
        mepc_q <= prv_if.mepc_next;
      if (prv_if.mcause_rup)
        mcause_q <= prv_if.mcause_next;
      if (prv_if.mbadaddr_rup)
        mbadaddr_q <= prv_if.mbadaddr_next;
      if (wr_mtimecmp)
        mtimecmp_q <= rup_data;

      if (wr_mtime)
        mtime_q <= {mtime_q[63:32], rup_data};
      else if (wr_mtimeh)
        mtime_q <= {rup_data, mtime_q[31:0]};
      else
        mtime_q <= mtime_q + 64'd1;

      cycle_q   <= cycle_q + 64'd1;   // Also serves as time
      instret_q <= instret_q + {63'd0, instr_retired};
    end
  end

  // Read mux, combinational from the address
  always_comb begin
    valid_addr = 1'b1;
    case (csr_addr)
      MCPUID_ADDR:   csr_rdata = mcpuid;
      MIMPID_ADDR:   csr_rdata = '0;
      MHARTID_ADDR:  csr_rdata = HART_ID;
      MSTATUS_ADDR:  csr_rdata = mstatus;
      MTVEC_ADDR:    csr_rdata = TRAP_VECTOR;
      MIE_ADDR:      csr_rdata = mie;
      MSCRATCH_ADDR: csr_rdata = mscratch_q;
      MEPC_ADDR:     csr_rdata = mepc_q;
      MCAUSE_ADDR:   csr_rdata = mcause_q.raw;
      MBADADDR_ADDR: csr_rdata = mbadaddr_q;
      MIP_ADDR:      csr_rdata = mip;
      MTIMECMP_ADDR: csr_rdata = mtimecmp_q;
      MTIME_ADDR:    csr_rdata = mtime_q[31:0];
      MTIMEH_ADDR:   csr_rdata = mtime_q[63:32];
      CYCLE_ADDR:    csr_rdata = cycle_q[31:0];
      CYCLEH_ADDR:   csr_rdata = cycle_q[63:32];
      INSTRET_ADDR:  csr_rdata = instret_q[31:0];
      INSTRETH_ADDR: csr_rdata = instret_q[63:32];
      default: begin
        valid_addr = 1'b0;
        csr_rdata  = '0;
      end
    endcase
  end

  assign prv_if.invalid_csr = csr_op & ~valid_addr;
  assign prv_if.mstatus     = mstatus;
  assign prv_if.mie         = mie;
  assign prv_if.mip         = mip;
  assign prv_if.mepc        = mepc_q;
  assign prv_if.mtvec       = TRAP_VECTOR;

  // The pipeline never issues two CSR ops at once
  a_one_csr_op: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({csr_swap, csr_set, csr_clr}));

  // Rearming the compare drops a pending timer interrupt on the next cycle
  a_mtip_cleared: assert property (@(posedge CLK) disable iff (!nRST)
    wr_mtimecmp |=> !prv_if.mip.mtip);

endmodule

/* machine_mode_pkg.sv */
// Machine-mode CSR addresses, register layouts and trap cause codes shared by the privilege unit
package machine_mode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;

  // Machine information registers
  localparam csr_addr_t MCPUID_ADDR   = 12'hF00;
  localparam csr_addr_t MIMPID_ADDR   = 12'hF01;
  localparam csr_addr_t MHARTID_ADDR  = 12'hF10;

  // Trap setup
  localparam csr_addr_t MSTATUS_ADDR  = 12'h300;
  localparam csr_addr_t MTVEC_ADDR    = 12'h301;
  localparam csr_addr_t MIE_ADDR      = 12'h304;
  localparam csr_addr_t MTIMECMP_ADDR = 12'h321;

  // Trap handling
  localparam csr_addr_t MSCRATCH_ADDR = 12'h340;
  localparam csr_addr_t MEPC_ADDR     = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR   = 12'h342;
  localparam csr_addr_t MBADADDR_ADDR = 12'h343;
  localparam csr_addr_t MIP_ADDR      = 12'h344;

  // Timer and user counters
  localparam csr_addr_t MTIME_ADDR    = 12'h701;
  localparam csr_addr_t MTIMEH_ADDR   = 12'h741;
  localparam csr_addr_t CYCLE_ADDR    = 12'hC00;
  localparam csr_addr_t INSTRET_ADDR  = 12'hC02;
  localparam csr_addr_t CYCLEH_ADDR   = 12'hC80;
  localparam csr_addr_t INSTRETH_ADDR = 12'hC82;

  localparam logic [1:0]  M_MODE       = 2'b11;
  localparam logic [1:0]  BASE_RV32    = 2'b00;
  localparam logic [25:0] MCPUID_EXT_I = 26'h000_0100;  // Letter I, bit 8

  typedef struct packed {
    logic       sd;
    logic [8:0] zero;
    logic [4:0] vm;      // Zero is MBARE
    logic       mprv;
    logic [1:0] xs;
    logic [1:0] fs;
    logic [1:0] prv3;
    logic       ie3;
    logic [1:0] prv2;
    logic       ie2;
    logic [1:0] prv1;
    logic       ie1;
    logic [1:0] prv;
    logic       ie;
  } mstatus_t;

  typedef struct packed {
    logic [23:0] zero_0;
    logic        mtie;
    logic        htie;
    logic        stie;
    logic        zero_1;
    logic        msie;
    logic        hsie;
    logic        ssie;
    logic        zero_2;
  } mie_t;

  typedef struct packed {
    logic [23:0] zero_0;
    logic        mtip;
    logic        htip;
    logic        stip;
    logic        zero_1;
    logic        msip;
    logic        hsip;
    logic        ssip;
    logic        zero_2;
  } mip_t;

  typedef logic [30:0] cause_code_t;

  typedef struct packed {
    logic        interrupt;
    cause_code_t code;
  } mcause_t;

  // Plain word for the CSR port, flag and code for the trap logic
  typedef union packed {
    word_t   raw;
    mcause_t fields;
  } mcause_u;

  localparam cause_code_t CAUSE_ILLEGAL_INSN = 31'd2;
  localparam cause_code_t CAUSE_SOFT_INT     = 31'd3;
  localparam cause_code_t CAUSE_LOAD_FAULT   = 31'd5;
  localparam cause_code_t CAUSE_TIMER_INT    = 31'd7;
  localparam cause_code_t CAUSE_ECALL_M      = 31'd11;

endpackage

/* priv_unit.sv */
// Machine-mode privilege unit top level; joins the CSR file and trap controller behind plain ports
`timescale 1ns/1ps

module priv_unit #(
  parameter machine_mode_pkg::word_t TRAP_VECTOR = 32'h0000_01C0,
  parameter machine_mode_pkg::word_t HART_ID     = 32'h0000_0000
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  machine_mode_pkg::csr_addr_t  csr_addr,
  input  logic                         csr_swap,
  input  logic                         csr_set,
  input  logic                         csr_clr,
  input  machine_mode_pkg::word_t      csr_wdata,
  output machine_mode_pkg::word_t      csr_rdata,
  input  logic                         instr_retired,
  input  logic                         soft_int,
  input  logic                         illegal_insn,
  input  logic                         ecall,
  input  logic                         load_fault,
  input  logic                         mret,
  input  machine_mode_pkg::word_t      epc,
  input  machine_mode_pkg::word_t      fault_addr,
  output logic                         insert_pc,
  output machine_mode_pkg::word_t      priv_pc
);

  prv_internal_if prv_if ();

  csr_rfile #(
    .TRAP_VECTOR (TRAP_VECTOR),
    .HART_ID     (HART_ID)
  ) csr_rfile_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .csr_addr      (csr_addr),
    .csr_swap      (csr_swap),
    .csr_set       (csr_set),
    .csr_clr       (csr_clr),
    .csr_wdata     (csr_wdata),
    .csr_rdata     (csr_rdata),
    .instr_retired (instr_retired),
    .prv_if        (prv_if.csr)
  );

  prv_control prv_control_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .csr_swap     (csr_swap),
    .csr_set      (csr_set),
    .csr_clr      (csr_clr),
    .soft_int     (soft_int),
    .illegal_insn (illegal_insn),
    .ecall        (ecall),
    .load_fault   (load_fault),
    .mret         (mret),
    .epc          (epc),
    .fault_addr   (fault_addr),
    .insert_pc    (insert_pc),
    .priv_pc      (priv_pc),
    .prv_if       (prv_if.prv)
  );

endmodule

/* prv_control.sv */
// Trap controller: ranks interrupts and exceptions, redirects the PC and updates the trap CSRs
`timescale 1ns/1ps

module prv_control (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     csr_swap,
  input  logic                     csr_set,
  input  logic                     csr_clr,
  input  logic                     soft_int,
  input  logic                     illegal_insn,
  input  logic                     ecall,
  input  logic                     load_fault,
  input  logic                     mret,
  input  machine_mode_pkg::word_t  epc,
  input  machine_mode_pkg::word_t  fault_addr,
  output logic                     insert_pc,
  output machine_mode_pkg::word_t  priv_pc,
  prv_internal_if.prv              prv_if
);
  import machine_mode_pkg::*;

  logic     csr_op;
  logic     illegal;
  logic     soft_pend;
  logic     timer_pend;
  logic     trap_taken;
  logic     fault_wins;
  mcause_u  cause;
  mstatus_t status_next;

  // Software interrupt is registered in mip by the CSR file
  assign prv_if.soft_int = soft_int;

  assign csr_op  = csr_swap | csr_set | csr_clr;
  assign illegal = illegal_insn | (csr_op & prv_if.invalid_csr);

  // Interrupts need the global enable and their own enable
  assign soft_pend  = prv_if.mstatus.ie & prv_if.mie.msie & prv_if.mip.msip;
  assign timer_pend = prv_if.mstatus.ie & prv_if.mie.mtie & prv_if.mip.mtip;

  assign trap_taken = soft_pend | timer_pend | illegal | ecall | load_fault;
  assign fault_wins = load_fault & ~(soft_pend | timer_pend | illegal | ecall);

  // Highest ranked source fills in the cause
  always_comb begin
    cause = '0;
    if (soft_pend) begin
      cause.fields.interrupt = 1'b1;
      cause.fields.code      = CAUSE_SOFT_INT;
    end else if (timer_pend) begin
      cause.fields.interrupt = 1'b1;
      cause.fields.code      = CAUSE_TIMER_INT;
    end else if (illegal) begin
      cause.fields.code = CAUSE_ILLEGAL_INSN;
    end else if (ecall) begin
      cause.fields.code = CAUSE_ECALL_M;
    end else if (load_fault) begin
      cause.fields.code = CAUSE_LOAD_FAULT;
    end
  end

  // Enable stack push on entry, pop on mret
  always_comb begin
    status_next = prv_if.mstatus;
    if (trap_taken) begin
      status_next.ie1 = prv_if.mstatus.ie;
      status_next.ie  = 1'b0;
    end else begin
      status_next.ie  = prv_if.mstatus.ie1;
      status_next.ie1 = 1'b1;
    end
  end

  assign insert_pc = trap_taken | mret;
  assign priv_pc   = trap_taken ? prv_if.mtvec : prv_if.mepc;

  assign prv_if.mstatus_rup   = insert_pc;
  assign prv_if.mstatus_next  = status_next;
  assign prv_if.mepc_rup      = trap_taken;
  assign prv_if.mepc_next     = epc;
  assign prv_if.mcause_rup    = trap_taken;
  assign prv_if.mcause_next   = cause;
  assign prv_if.mbadaddr_rup  = fault_wins;  // Only a load fault carries an address
  assign prv_if.mbadaddr_next = fault_addr;

  // Trap return and trap entry are exclusive in a cycle
  a_mret_no_trap: assert property (@(posedge CLK) disable iff (!nRST)
    !(mret && trap_taken));

endmodule

/* prv_internal_if.sv */
// Register views and trap update strobes passed between the CSR file and the trap controller
`timescale 1ns/1ps

interface prv_internal_if;
  import machine_mode_pkg::*;

  // Views out of the CSR file
  mstatus_t mstatus;
  mie_t     mie;
  mip_t     mip;
  word_t    mepc;
  word_t    mtvec;
  logic     invalid_csr;   // CSR op on an unimplemented address

  // Updates from the trap controller
  logic     mstatus_rup;
  logic     mepc_rup;
  logic     mcause_rup;
  logic     mbadaddr_rup;
  mstatus_t mstatus_next;
  word_t    mepc_next;
  mcause_u  mcause_next;
  word_t    mbadaddr_next;
  logic     soft_int;      // Sampled into mip.msip

  modport csr (
    output mstatus, mie, mip, mepc, mtvec, invalid_csr,
    input  mstatus_rup, mepc_rup, mcause_rup, mbadaddr_rup,
    input  mstatus_next, mepc_next, mcause_next, mbadaddr_next,
    input  soft_int
  );

  modport prv (
    input  mstatus, mie, mip, mepc, mtvec, invalid_csr,
    output mstatus_rup, mepc_rup, mcause_rup, mbadaddr_rup,
    output mstatus_next, mepc_next, mcause_next, mbadaddr_next,
    output soft_int
  );

endinterface

/* tb_priv_model.svh */
// Reference model and typed compare tasks included inside the privilege unit testbench module
`ifndef TB_PRIV_MODEL_SVH
`define TB_PRIV_MODEL_SVH

  // New CSR value for one swap, set or clear access
  function automatic word_t rmw_result(word_t old, word_t wdata, bit swap, bit set, bit clr);
    if (swap)
      return wdata;
    if (clr)
      return old & ~wdata;
    if (set)
      return old | wdata;
    return old;
  endfunction

  // Trap source with the highest rank wins
  function automatic mcause_u expected_cause(bit soft_irq, bit timer, bit illegal, bit ecall_in,
                                             bit fault);
    mcause_u c;
    c.raw = '0;
    if (soft_irq) begin
      c.fields.interrupt = 1'b1;
      c.fields.code      = CAUSE_SOFT_INT;
    end else if (timer) begin
      c.fields.interrupt = 1'b1;
      c.fields.code      = CAUSE_TIMER_INT;
    end else if (illegal) begin
      c.fields.code = CAUSE_ILLEGAL_INSN;
    end else if (ecall_in) begin
      c.fields.code = CAUSE_ECALL_M;
    end else if (fault) begin
      c.fields.code = CAUSE_LOAD_FAULT;
    end
    return c;
  endfunction

  function automatic word_t trap_target(bit trap, word_t mtvec, word_t mepc);
    return trap ? mtvec : mepc;  // mret goes back to mepc
  endfunction

  // All privilege fields read as machine mode
  function automatic word_t mstatus_word(bit ie1, bit ie);
    mstatus_t s;
    s      = '0;
    s.prv  = M_MODE;
    s.prv1 = M_MODE;
    s.prv2 = M_MODE;
    s.prv3 = M_MODE;
    s.ie1  = ie1;
    s.ie   = ie;
    return word_t'(s);
  endfunction

  task automatic check_word(word_t actual, word_t expected, string what);
    if (actual !== expected)
      abort_run($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual,
                          expected));
  endtask

  task automatic check_cause(mcause_u actual, mcause_u expected, string what);
    if (actual.raw !== expected.raw)
      abort_run($sformatf("FAIL at %0t ns: %s is flag %0b code %0d, expected flag %0b code %0d",
                          $time, what, actual.fields.interrupt, actual.fields.code,
                          expected.fields.interrupt, expected.fields.code));
  endtask

  task automatic check_flag(bit actual, bit expected, string what);
    if (actual !== expected)
      abort_run($sformatf("FAIL at %0t ns: %s is %0b, expected %0b", $time, what, actual,
                          expected));
  endtask

`endif

/* tb_priv_unit.sv */
// Testbench for the privilege unit; runs CSR access, counter, timer and trap sequences on the DUT
`timescale 1ns/1ps

module tb_priv_unit;
  import machine_mode_pkg::*;

  localparam word_t TRAP_VECTOR    = 32'h0000_01C0;
  localparam word_t HART_ID        = 32'h0000_0005;
  localparam int    N_RMW          = 40;
  localparam int    TIMEOUT_CYCLES = 2000;  // About 200 cycles of tests plus wide margin

  logic      CLK;
  logic      nRST;
  csr_addr_t csr_addr;
  logic      csr_swap;
  logic      csr_set;
  logic      csr_clr;
  word_t     csr_wdata;
  word_t     csr_rdata;
  logic      instr_retired;
  logic      soft_int;
  logic      illegal_insn;
  logic      ecall;
  logic      load_fault;
  logic      mret;
  word_t     epc;
  word_t     fault_addr;
  logic      insert_pc;
  word_t     priv_pc;

  // Expectations armed with the stimulus, checked before the next edge
  bit      chk_rdata;
  bit      chk_cause;
  bit      chk_insert;
  bit      chk_pc;
  word_t   exp_rdata;
  word_t   exp_pc;
  mcause_u exp_cause;
  bit      exp_insert;
  string   chk_name;
  word_t   seen_rdata;
  word_t   seen_pc;
  logic    seen_insert;
  integer  seed;
  int      cycles = 0;

  task automatic abort_run(string line);
    $display("%s", line);
    $display("tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  `include "tb_priv_model.svh"

  priv_unit #(
    .TRAP_VECTOR (TRAP_VECTOR),
    .HART_ID     (HART_ID)
  ) dut_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .csr_addr      (csr_addr),
    .csr_swap      (csr_swap),
    .csr_set       (csr_set),
    .csr_clr       (csr_clr),
    .csr_wdata     (csr_wdata),
    .csr_rdata     (csr_rdata),
    .instr_retired (instr_retired),
    .soft_int      (soft_int),
    .illegal_insn  (illegal_insn),
    .ecall         (ecall),
    .load_fault    (load_fault),
    .mret          (mret),
    .epc           (epc),
    .fault_addr    (fault_addr),
    .insert_pc     (insert_pc),
    .priv_pc       (priv_pc)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
      abort_run($sformatf("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  // Compare process, mid-cycle where all outputs have settled
  always @(negedge CLK) begin
    seen_rdata  = csr_rdata;
    seen_pc     = priv_pc;
    seen_insert = insert_pc;
    if (chk_rdata)
      check_word(csr_rdata, exp_rdata, chk_name);
    if (chk_cause)
      check_cause(mcause_u'(csr_rdata), exp_cause, chk_name);
    if (chk_insert)
      check_flag(insert_pc, exp_insert, "insert_pc");
    if (chk_pc)
      check_word(priv_pc, exp_pc, "priv_pc");
  end

  // Step past the next edge, pulses and checks back to idle
  task automatic next_cycle();
    @(posedge CLK);
    #1;
    csr_swap      = 1'b0;
    csr_set       = 1'b0;
    csr_clr       = 1'b0;
    instr_retired = 1'b0;
    illegal_insn  = 1'b0;
    ecall         = 1'b0;
    load_fault    = 1'b0;
    mret          = 1'b0;
    chk_rdata     = 1'b0;
    chk_cause     = 1'b0;
    chk_insert    = 1'b0;
    chk_pc        = 1'b0;
  endtask

  // op 0 swap, 1 set, 2 clear, anything else read only
  task automatic drive_csr(csr_addr_t addr, int op, word_t wdata);
    csr_addr  = addr;
    csr_wdata = wdata;
    csr_swap  = (op == 0);
    csr_set   = (op == 1);
    csr_clr   = (op == 2);
  endtask

  task automatic expect_read(csr_addr_t addr, word_t value, string name);
    csr_addr  = addr;
    exp_rdata = value;
    chk_rdata = 1'b1;
    chk_name  = name;
  endtask

  task automatic expect_cause_read(mcause_u value, string name);
    csr_addr  = MCAUSE_ADDR;
    exp_cause = value;
    chk_cause = 1'b1;
    chk_name  = name;
  endtask

  task automatic expect_redirect(word_t pc);
    exp_insert = 1'b1;
    chk_insert = 1'b1;
    exp_pc     = pc;
    chk_pc     = 1'b1;
  endtask

  task automatic run_rmw_test();
    word_t     model [2] = '{default: '0};
    csr_addr_t addr;
    word_t     wdata;
    int        op;
    int        sel;
    for (int i = 0; i < N_RMW; i++) begin
      sel   = {$random(seed)} % 2;
      op    = {$random(seed)} % 3;
      wdata = $random(seed);
      addr  = sel ? MEPC_ADDR : MSCRATCH_ADDR;
      drive_csr(addr, op, wdata);
      expect_read(addr, model[sel], "csr old value");
      model[sel] = rmw_result(model[sel], wdata, op == 0, op == 1, op == 2);
      next_cycle();
      expect_read(addr, model[sel], "csr read back");
      next_cycle();
    end
    drive_csr(MHARTID_ADDR, 0, $random(seed));
    expect_read(MHARTID_ADDR, HART_ID, "mhartid");
    next_cycle();
    expect_read(MHARTID_ADDR, HART_ID, "mhartid after write");
    next_cycle();
  endtask

  task automatic run_illegal_csr_test();
    word_t saved;
    saved = $random(seed) & ~32'h3;
    epc   = saved;
    drive_csr(12'h123, 0, 32'hDEAD_BEEF);  // Unimplemented address
    expect_redirect(trap_target(1'b1, TRAP_VECTOR, saved));
    next_cycle();
    expect_cause_read(expected_cause(0, 0, 1, 0, 0), "mcause after bad csr");
    next_cycle();
    expect_read(MEPC_ADDR, saved, "mepc after bad csr");
    next_cycle();
    mret = 1'b1;
    expect_redirect(trap_target(1'b0, TRAP_VECTOR, saved));
    next_cycle();
  endtask

  task automatic run_counter_test();
    word_t first;
    word_t base;
    int    pulses;
    pulses   = 0;
    csr_addr = CYCLE_ADDR;
    next_cycle();
    first = seen_rdata;
    expect_read(CYCLE_ADDR, first + 1, "cycle step");
    next_cycle();
    csr_addr = INSTRET_ADDR;
    next_cycle();
    base = seen_rdata;
    for (int i = 0; i < 16; i++) begin
      instr_retired = ($random(seed) % 2 != 0);
      pulses += instr_retired;
      next_cycle();
    end
    expect_read(INSTRET_ADDR, base + pulses, "instret count");
    next_cycle();
  endtask

  task automatic run_timer_test();
    word_t start;
    word_t target;
    int    waited;
    start  = $random(seed) & 32'h00FF_FFFF;  // Far from wrap
    target = start + 20;
    drive_csr(MTIME_ADDR, 0, start);
    next_cycle();
    drive_csr(MTIMECMP_ADDR, 0, target);
    next_cycle();
    epc = 32'h0000_2000;
    drive_csr(MIE_ADDR, 1, 32'h0000_0080);  // mtie
    next_cycle();
    waited = 1;
    do begin
      csr_addr = MTIME_ADDR;
      next_cycle();
      waited++;
    end while (!seen_insert && waited < 25);
    check_flag(seen_insert, 1'b1, "timer interrupt within 25 cycles");
    check_flag(seen_rdata >= target, 1'b1, "mtime reached mtimecmp at interrupt");
    check_word(seen_pc, TRAP_VECTOR, "timer trap pc");
    expect_cause_read(expected_cause(0, 1, 0, 0, 0), "mcause after timer");
    next_cycle();
    drive_csr(MIE_ADDR, 2, 32'h0000_0080);
    next_cycle();
    mret = 1'b1;
    expect_redirect(trap_target(1'b0, TRAP_VECTOR, 32'h0000_2000));
    next_cycle();
  endtask

  task automatic run_ecall_test();
    word_t saved;
    saved = $random(seed) & ~32'h3;
    epc   = saved;
    ecall = 1'b1;
    expect_redirect(trap_target(1'b1, TRAP_VECTOR, saved));
    next_cycle();
    expect_read(MSTATUS_ADDR, mstatus_word(1'b1, 1'b0), "mstatus after ecall");
    next_cycle();
    expect_cause_read(expected_cause(0, 0, 0, 1, 0), "mcause after ecall");
    next_cycle();
    mret = 1'b1;
    expect_redirect(trap_target(1'b0, TRAP_VECTOR, saved));
    next_cycle();
    expect_read(MSTATUS_ADDR, mstatus_word(1'b1, 1'b1), "mstatus after mret");
    next_cycle();
  endtask

  task automatic run_priority_test();
    drive_csr(MIE_ADDR, 1, 32'h0000_0008);  // msie
    next_cycle();
    soft_int = 1'b1;
    next_cycle();
    fault_addr = $random(seed);
    load_fault = 1'b1;
    ecall      = 1'b1;
    expect_redirect(trap_target(1'b1, TRAP_VECTOR, epc));
    next_cycle();
    expect_cause_read(expected_cause(1, 0, 0, 1, 1), "mcause soft over exceptions");
    next_cycle();
    soft_int = 1'b0;
    drive_csr(MIE_ADDR, 2, 32'h0000_0008);
    next_cycle();
    mret = 1'b1;
    expect_redirect(trap_target(1'b0, TRAP_VECTOR, epc));
    next_cycle();
    soft_int = 1'b1;  // Pending but msie now off
    next_cycle();
    fault_addr = $random(seed);
    load_fault = 1'b1;
    ecall      = 1'b1;
    expect_redirect(trap_target(1'b1, TRAP_VECTOR, epc));
    next_cycle();
    expect_cause_read(expected_cause(0, 0, 0, 1, 1), "mcause ecall over load fault");
    next_cycle();
    expect_read(MBADADDR_ADDR, '0, "mbadaddr unchanged");
    next_cycle();
    soft_int = 1'b0;
    mret     = 1'b1;
    next_cycle();
  endtask

  initial begin
    seed          = 87;
    nRST          = 1'b0;
    csr_addr      = '0;
    csr_swap      = 1'b0;
    csr_set       = 1'b0;
    csr_clr       = 1'b0;
    csr_wdata     = '0;
    instr_retired = 1'b0;
    soft_int      = 1'b0;
    illegal_insn  = 1'b0;
    ecall         = 1'b0;
    load_fault    = 1'b0;
    mret          = 1'b0;
    epc           = '0;
    fault_addr    = '0;
    chk_name      = "";
    repeat (4) @(posedge CLK);
    #1;
    nRST = 1'b1;
    expect_read(MSTATUS_ADDR, mstatus_word(1'b0, 1'b1), "mstatus after reset");
    exp_insert = 1'b0;
    chk_insert = 1'b1;
    next_cycle();
    run_rmw_test();
    run_illegal_csr_test();
    run_counter_test();
    run_timer_test();
    run_ecall_test();
    run_priority_test();
    $display("all tests passed");
    $finish;
  end

endmodule
